/* source/elevator_cfg.svh */
// configuration macros: floor count, travel and door timers, weight sensor width and limit
`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

// --------------------------------------------------
// building
// --------------------------------------------------
`define ELEV_NUM_FLOORS   8     // floors served
`define ELEV_FLOOR_BITS   3     // width of a floor number

// --------------------------------------------------
// timing in CLK cycles
// --------------------------------------------------
`define ELEV_FLOOR_TICKS  16    // travel time per floor
`define ELEV_DOOR_TICKS   12    // door hold time

// --------------------------------------------------
// weight sensor
// --------------------------------------------------
`define ELEV_WEIGHT_BITS  10    // sensor reading width
`define ELEV_MAX_WEIGHT   500   // highest load in kg that lets the doors close

`endif

/* source/elevator_pkg.sv */
// elevator types: floor number, floor mask, direction and state enums, cabin status struct

`include "elevator_cfg.svh"

package elevator_pkg;

  // --------------------------------------------------
  // floor encodings
  // --------------------------------------------------
  typedef logic [`ELEV_FLOOR_BITS-1:0] floor_t;       // binary floor number
  typedef logic [`ELEV_NUM_FLOORS-1:0] floor_mask_t;  // one bit per floor

  // --------------------------------------------------
  // enums
  // --------------------------------------------------
  typedef enum logic [1:0] {
    DIR_IDLE = 2'd0,  // no pending calls
    DIR_UP   = 2'd1,
    DIR_DOWN = 2'd2
  } dir_e;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,  // at rest, doors closed
    ST_MOVE      = 2'd1,  // travelling between floors
    ST_DOOR_OPEN = 2'd2   // doors held open
  } cabin_state_e;

  // cabin status as seen by the scheduler, call register and outside world
  typedef struct packed {
    floor_t floor;      // current floor
    dir_e   dir;        // sweep direction
    logic   door_open;  // doors open level
  } cabin_status_t;

endpackage

/* source/call_register.sv */
// cabin call register: button latching, served-call clearing and light outputs
`timescale 1ns/1ns

module call_register (
  input  logic                        CLK,
  input  logic                        RESET,
  input  elevator_pkg::floor_mask_t   buttons_i,  // cabin floor buttons
  input  elevator_pkg::cabin_status_t status_i,   // floor and door state
  output elevator_pkg::floor_mask_t   calls_o     // pending calls, also the lights
);

  elevator_pkg::floor_mask_t calls_q;      // latched calls
  elevator_pkg::floor_mask_t served_mask;  // floor being served right now

  // --------------------------------------------------
  // served floor
  // --------------------------------------------------
  // the floor with open doors is both cleared and blocked for new presses
  always_comb begin
    served_mask = '0;
    if (status_i.door_open) begin
      served_mask[status_i.floor] = 1'b1;
    end
  end

  // --------------------------------------------------
  // call latch
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RESET) begin
      calls_q <= '0;  // all lights off
    end else begin
      calls_q <= (calls_q | buttons_i) & ~served_mask;  // set on press, clear when served
    end
  end

  assign calls_o = calls_q;

endmodule

/* source/next_floor_ctrl.sv */
// next-floor scheduler: collective up/down sweep with registered direction
`timescale 1ns/1ns

`include "elevator_cfg.svh"

module next_floor_ctrl (
  input  logic                      CLK,
  input  logic                      RESET,
  input  elevator_pkg::floor_mask_t calls_i,          // pending cabin calls
  input  elevator_pkg::floor_t      current_floor_i,  // cabin position
  output elevator_pkg::floor_t      target_floor_o,   // chosen stop
  output logic                      target_valid_o,   // any call pending
  output elevator_pkg::dir_e        dir_o             // sweep direction
);

  elevator_pkg::dir_e   dir_q;        // registered sweep direction
  elevator_pkg::dir_e   dir_d;
  elevator_pkg::floor_t above_floor;  // nearest call above
  elevator_pkg::floor_t below_floor;  // nearest call below
  elevator_pkg::floor_t target;
  logic                 above_found;
  logic                 below_found;

  // --------------------------------------------------
  // call scan
  // --------------------------------------------------
  // scan from the far end toward the cabin so the last hit is the nearest one
  always_comb begin
    above_found = 1'b0;
    above_floor = '0;
    for (int i = `ELEV_NUM_FLOORS - 1; i >= 0; i--) begin
      if (calls_i[i] && (i > int'(current_floor_i))) begin
        above_found = 1'b1;
        above_floor = elevator_pkg::floor_t'(i);
      end
    end
    below_found = 1'b0;
    below_floor = '0;
    for (int i = 0; i < `ELEV_NUM_FLOORS; i++) begin
      if (calls_i[i] && (i < int'(current_floor_i))) begin
        below_found = 1'b1;
        below_floor = elevator_pkg::floor_t'(i);
      end
    end
  end

  // --------------------------------------------------
  // target and direction
  // --------------------------------------------------
  always_comb begin
    if (calls_i[current_floor_i]) begin
      target = current_floor_i;                            // serve this floor first
    end else if (dir_q != elevator_pkg::DIR_DOWN) begin
      target = above_found ? above_floor : below_floor;    // up or idle prefers up
    end else begin
      target = below_found ? below_floor : above_floor;
    end

    if (!target_valid_o) begin
      dir_d = elevator_pkg::DIR_IDLE;
    end else if (target > current_floor_i) begin
      dir_d = elevator_pkg::DIR_UP;
    end else if (target < current_floor_i) begin
      dir_d = elevator_pkg::DIR_DOWN;
    end else begin
      dir_d = dir_q;  // stop at this floor keeps the sweep going
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      dir_q <= elevator_pkg::DIR_IDLE;
    end else begin
      dir_q <= dir_d;
    end
  end

  assign target_valid_o = |calls_i;
  assign target_floor_o = target;
  assign dir_o          = dir_q;

endmodule

/* source/cabin_ctrl.sv */
// cabin FSM: floor travel timer, door hold timer, manual door buttons and overload hold
`timescale 1ns/1ns

`include "elevator_cfg.svh"

module cabin_ctrl (
  input  logic                         CLK,
  input  logic                         RESET,
  input  elevator_pkg::floor_t         target_floor_i,    // stop chosen by scheduler
  input  logic                         target_valid_i,    // a call is pending
  input  elevator_pkg::dir_e           dir_i,             // sweep direction for status
  input  logic                         door_open_btn_i,   // manual open
  input  logic                         door_close_btn_i,  // manual close
  input  logic [`ELEV_WEIGHT_BITS-1:0] weight_i,          // load sensor reading
  output elevator_pkg::cabin_status_t  status_o
);

  // --------------------------------------------------
  // timer constants
  // --------------------------------------------------
  localparam int TRAVEL_W = $clog2(`ELEV_FLOOR_TICKS);
  localparam int DOOR_W   = $clog2(`ELEV_DOOR_TICKS);

  localparam logic [TRAVEL_W-1:0] TRAVEL_LAST = TRAVEL_W'(`ELEV_FLOOR_TICKS - 1);
  localparam logic [DOOR_W-1:0]   DOOR_LAST   = DOOR_W'(`ELEV_DOOR_TICKS - 1);

  localparam logic [`ELEV_WEIGHT_BITS-1:0] MAX_WEIGHT = `ELEV_MAX_WEIGHT;

  elevator_pkg::cabin_state_e state_q;
  elevator_pkg::floor_t       floor_q;     // current floor
  logic [TRAVEL_W-1:0]        travel_cnt;  // cycles spent on the current floor step
  logic [DOOR_W-1:0]          door_cnt;    // cycles the doors have been open
  logic                       overload;

  assign overload = weight_i > MAX_WEIGHT;  // doors must stay open

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RESET) begin
      state_q    <= elevator_pkg::ST_IDLE;
      floor_q    <= '0;
      travel_cnt <= '0;
      door_cnt   <= '0;
    end else begin
      case (state_q)
        elevator_pkg::ST_IDLE: begin
          if (door_open_btn_i || (target_valid_i && (target_floor_i == floor_q))) begin
            state_q  <= elevator_pkg::ST_DOOR_OPEN;  // open here
            door_cnt <= '0;
          end else if (target_valid_i) begin
            state_q    <= elevator_pkg::ST_MOVE;     // target elsewhere
            travel_cnt <= '0;
          end
        end

        elevator_pkg::ST_MOVE: begin
          if (target_floor_i == floor_q) begin
            state_q  <= elevator_pkg::ST_DOOR_OPEN;  // arrived
            door_cnt <= '0;
          end else if (travel_cnt == TRAVEL_LAST) begin
            travel_cnt <= '0;
            if (target_floor_i > floor_q) begin
              floor_q <= floor_q + elevator_pkg::floor_t'(1);
            end else begin
              floor_q <= floor_q - elevator_pkg::floor_t'(1);
            end
          end else begin
            travel_cnt <= travel_cnt + 1'b1;
          end
        end

        elevator_pkg::ST_DOOR_OPEN: begin
          // open restarts the hold, overload pauses it and blocks closing
          if (door_open_btn_i) begin
            door_cnt <= '0;
          end else if (!overload) begin
            if (door_close_btn_i || (door_cnt == DOOR_LAST)) begin
              state_q <= elevator_pkg::ST_IDLE;
            end else begin
              door_cnt <= door_cnt + 1'b1;
            end
          end
        end

        default: begin
          state_q <= elevator_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // status
  // --------------------------------------------------
  assign status_o.floor     = floor_q;
  assign status_o.dir       = dir_i;  // scheduler direction passed through
  assign status_o.door_open = (state_q == elevator_pkg::ST_DOOR_OPEN);

endmodule

/* source/elevator_top.sv */
// elevator top level: call register, next-floor scheduler and cabin controller
`timescale 1ns/1ns

`include "elevator_cfg.svh"

module elevator_top (
  input  logic                         CLK,
  input  logic                         RESET,
  input  elevator_pkg::floor_mask_t    call_buttons_i,    // cabin floor buttons
  input  logic                         door_open_btn_i,
  input  logic                         door_close_btn_i,
  input  logic [`ELEV_WEIGHT_BITS-1:0] weight_i,          // load sensor
  output elevator_pkg::floor_mask_t    call_lights_o,     // button lights
  output elevator_pkg::cabin_status_t  status_o           // floor, direction, doors
);

  elevator_pkg::floor_t target_floor;
  logic                 target_valid;
  elevator_pkg::dir_e   sweep_dir;

  // --------------------------------------------------
  // keyboard side
  // --------------------------------------------------
  call_register i_call_register (
    .CLK       (CLK),
    .RESET     (RESET),
    .buttons_i (call_buttons_i),
    .status_i  (status_o),
    .calls_o   (call_lights_o)   // lights double as the call mask
  );

  // --------------------------------------------------
  // scheduling and cabin
  // --------------------------------------------------
  next_floor_ctrl i_next_floor_ctrl (
    .CLK             (CLK),
    .RESET           (RESET),
    .calls_i         (call_lights_o),
    .current_floor_i (status_o.floor),
    .target_floor_o  (target_floor),
    .target_valid_o  (target_valid),
    .dir_o           (sweep_dir)
  );

  cabin_ctrl i_cabin_ctrl (
    .CLK              (CLK),
    .RESET            (RESET),
    .target_floor_i   (target_floor),
    .target_valid_i   (target_valid),
    .dir_i            (sweep_dir),
    .door_open_btn_i  (door_open_btn_i),
    .door_close_btn_i (door_close_btn_i),
    .weight_i         (weight_i),
    .status_o         (status_o)
  );

endmodule

/* sim/elevator_tb.sv */
// elevator testbench: clock, reset, timeout, compare tasks and directed tests
`timescale 1ns/1ns

`include "elevator_cfg.svh"

module elevator_tb;

  // about 7 floors x 16 cycles plus door time per test, six tests well inside the limit
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int DOOR           = `ELEV_DOOR_TICKS;

  logic                         CLK;
  logic                         RESET;
  elevator_pkg::floor_mask_t    call_buttons;
  logic                         door_open_btn;
  logic                         door_close_btn;
  logic [`ELEV_WEIGHT_BITS-1:0] weight;
  elevator_pkg::floor_mask_t    call_lights;
  elevator_pkg::cabin_status_t  status;
  int                           cycles;  // rising edges so far
  int unsigned                  seed;

  elevator_top i_dut (
    .CLK              (CLK),
    .RESET            (RESET),
    .call_buttons_i   (call_buttons),
    .door_open_btn_i  (door_open_btn),
    .door_close_btn_i (door_close_btn),
    .weight_i         (weight),
    .call_lights_o    (call_lights),
    .status_o         (status)
  );

  // --------------------------------------------------
  // clock, cycle count and timeout
  // --------------------------------------------------
  always #2 CLK = ~CLK;  // 4 ns period

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("simulation timed out after %0d cycles", cycles);
      abort_run();
    end
  end

  // --------------------------------------------------
  // failure and compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_lights(string name, elevator_pkg::floor_mask_t exp,
                                elevator_pkg::floor_mask_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_floor(string name, elevator_pkg::floor_t exp, elevator_pkg::floor_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_status(string name, elevator_pkg::cabin_status_t exp,
                                elevator_pkg::cabin_status_t act);
    if (act !== exp) begin
      $display(
        "error at %0t ns: %s expected floor %0d dir %0d door %b, got floor %0d dir %0d door %b",
        $time, name, exp.floor, exp.dir, exp.door_open, act.floor, act.dir, act.door_open);
      abort_run();
    end
  endtask

  task automatic compare_cycles(string name, int exp, int act);
    if (act != exp) begin
      $display("error at %0t ns: %s expected %0d cycles, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // stimulus and wait helpers
  // --------------------------------------------------
  function automatic elevator_pkg::cabin_status_t expected_status(elevator_pkg::floor_t f,
      elevator_pkg::dir_e d, logic open);
    elevator_pkg::cabin_status_t s;
    s.floor     = f;
    s.dir       = d;
    s.door_open = open;
    return s;
  endfunction

  function automatic elevator_pkg::floor_mask_t floor_bit(int f);
    elevator_pkg::floor_mask_t m;
    m    = '0;
    m[f] = 1'b1;
    return m;
  endfunction

  // one-cycle press that returns at the falling edge after the latch
  task automatic press_call(elevator_pkg::floor_mask_t mask);
    @(posedge CLK);
    call_buttons <= mask;
    @(posedge CLK);
    call_buttons <= '0;
    @(negedge CLK);
  endtask

  task automatic press_open();
    @(posedge CLK);
    door_open_btn <= 1'b1;
    @(posedge CLK);
    door_open_btn <= 1'b0;
    @(negedge CLK);
  endtask

  task automatic wait_floor_change();
    elevator_pkg::floor_t start;
    int                   t0;
    start = status.floor;
    t0    = cycles;
    while (status.floor == start) begin
      @(negedge CLK);
      if (cycles - t0 > `ELEV_FLOOR_TICKS + 2) begin
        $display("cabin stayed at floor %0d longer than one floor travel time", start);
        abort_run();
      end
    end
  endtask

  task automatic wait_door_open(int limit);
    int t0;
    t0 = cycles;
    while (!status.door_open) begin
      @(negedge CLK);
      if (cycles - t0 > limit) begin
        $display("doors did not open within %0d cycles", limit);
        abort_run();
      end
    end
  endtask

  // n counts edges from the call until the edge that closed the doors
  task automatic wait_door_closed(int limit, output int n);
    int t0;
    t0 = cycles;
    while (status.door_open) begin
      @(negedge CLK);
      if (cycles - t0 > limit) begin
        $display("doors still open %0d cycles after they should have closed", cycles - t0);
        abort_run();
      end
    end
    n = cycles - t0;
  endtask

  // ride from origin to dest floor by floor, then check the stop and the door hold
  task automatic ride_and_serve(elevator_pkg::floor_t origin, elevator_pkg::floor_t dest,
                                elevator_pkg::dir_e move_dir, elevator_pkg::dir_e dir_after,
                                elevator_pkg::floor_mask_t lights);
    elevator_pkg::floor_t exp_floor;
    int                   t_prev;
    int                   open_cycles;
    exp_floor = origin;
    t_prev    = cycles + 1;  // travel starts one edge after the call is seen
    while (exp_floor != dest) begin
      exp_floor = (move_dir == elevator_pkg::DIR_UP) ? exp_floor + 1'b1 : exp_floor - 1'b1;
      wait_floor_change();
      compare_floor("status_o.floor", exp_floor, status.floor);
      compare_cycles("floor step interval", `ELEV_FLOOR_TICKS, cycles - t_prev);
      t_prev = cycles;
    end
    wait_door_open(2);
    compare_status("status_o", expected_status(dest, move_dir, 1'b1), status);
    wait_door_closed(DOOR + 2, open_cycles);
    compare_cycles("door open time", DOOR, open_cycles);
    compare_lights("call_lights_o", lights, call_lights);
    compare_status("status_o", expected_status(dest, dir_after, 1'b0), status);
  endtask

  task automatic pulse_buttons_while_moving();
    repeat (5) @(posedge CLK);
    door_open_btn <= 1'b1;
    @(posedge CLK);
    door_open_btn <= 1'b0;
    repeat (20) @(posedge CLK);
    door_close_btn <= 1'b1;
    @(posedge CLK);
    door_close_btn <= 1'b0;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic after_reset();
    compare_status("status_o", expected_status(0, elevator_pkg::DIR_IDLE, 1'b0), status);
    compare_lights("call_lights_o", '0, call_lights);
  endtask

  task automatic single_call();
    press_call(floor_bit(5));
    compare_lights("call_lights_o", floor_bit(5), call_lights);
    ride_and_serve(0, 5, elevator_pkg::DIR_UP, elevator_pkg::DIR_IDLE, '0);
  endtask

  task automatic sweep_order();
    press_call(floor_bit(2) | floor_bit(7));
    compare_lights("call_lights_o", floor_bit(2) | floor_bit(7), call_lights);
    ride_and_serve(5, 7, elevator_pkg::DIR_UP, elevator_pkg::DIR_DOWN, floor_bit(2));
    ride_and_serve(7, 2, elevator_pkg::DIR_DOWN, elevator_pkg::DIR_IDLE, '0);
  endtask

  task automatic manual_buttons();
    int n;
    press_open();  // idle reopen gets the full hold
    compare_status("status_o", expected_status(2, elevator_pkg::DIR_IDLE, 1'b1), status);
    wait_door_closed(DOOR + 2, n);
    compare_cycles("door open time", DOOR, n);
    press_open();
    repeat (3) @(posedge CLK);
    door_close_btn <= 1'b1;
    @(negedge CLK);
    compare_status("status_o", expected_status(2, elevator_pkg::DIR_IDLE, 1'b1), status);
    @(posedge CLK);
    door_close_btn <= 1'b0;
    @(negedge CLK);
    compare_status("status_o", expected_status(2, elevator_pkg::DIR_IDLE, 1'b0), status);
    press_call(floor_bit(4));
    fork
      ride_and_serve(2, 4, elevator_pkg::DIR_UP, elevator_pkg::DIR_IDLE, '0);
      pulse_buttons_while_moving();
    join
  endtask

  task automatic overload_hold();
    int n;
    @(posedge CLK);
    weight <= `ELEV_WEIGHT_BITS'(`ELEV_MAX_WEIGHT + 1 +
              ($urandom % ((1 << `ELEV_WEIGHT_BITS) - 1 - `ELEV_MAX_WEIGHT)));
    press_open();
    repeat (3 * DOOR) begin
      @(negedge CLK);
      compare_status("status_o", expected_status(4, elevator_pkg::DIR_IDLE, 1'b1), status);
    end
    @(posedge CLK);
    door_close_btn <= 1'b1;
    @(posedge CLK);
    door_close_btn <= 1'b0;
    @(negedge CLK);
    compare_status("status_o", expected_status(4, elevator_pkg::DIR_IDLE, 1'b1), status);
    @(posedge CLK);
    weight <= `ELEV_WEIGHT_BITS'($urandom % (`ELEV_MAX_WEIGHT + 1));
    @(negedge CLK);
    wait_door_closed(DOOR, n);  // hold never advanced under overload so all of it remains
    compare_cycles("door hold after overload", DOOR, n);
    compare_status("status_o", expected_status(4, elevator_pkg::DIR_IDLE, 1'b0), status);
  endtask

  task automatic current_floor_press();
    int n;
    press_open();
    press_call(floor_bit(4));  // doors open at floor 4
    compare_lights("call_lights_o", '0, call_lights);
    wait_door_closed(DOOR + 2, n);
    compare_cycles("door hold after floor press", DOOR - 2, n);
    repeat (2 * DOOR) begin
      @(negedge CLK);
      compare_lights("call_lights_o", '0, call_lights);
      compare_status("status_o", expected_status(4, elevator_pkg::DIR_IDLE, 1'b0), status);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    seed = 32'hbc06;
    void'($urandom(seed));
    cycles         = 0;
    CLK            = 1'b0;
    RESET          = 1'b1;
    call_buttons   = '0;
    door_open_btn  = 1'b0;
    door_close_btn = 1'b0;
    weight         = `ELEV_WEIGHT_BITS'($urandom % (`ELEV_MAX_WEIGHT + 1));
    repeat (10) @(posedge CLK);
    RESET <= 1'b0;
    @(negedge CLK);
    after_reset();
    single_call();
    sweep_order();
    manual_buttons();
    overload_hold();
    current_floor_press();
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* elevator_top.f */
+incdir+source
source/elevator_pkg.sv
source/call_register.sv
source/next_floor_ctrl.sv
source/cabin_ctrl.sv
source/elevator_top.sv
sim/elevator_tb.sv

/* Bender.yml */
package:
  name: elevator

sources:
  - include_dirs:
      - source
    files:
      - source/elevator_pkg.sv
      - source/call_register.sv
      - source/next_floor_ctrl.sv
      - source/cabin_ctrl.sv
      - source/elevator_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/elevator_tb.sv
